// ==== build.f ====
design/mainbd_pkg.sv
design/mainbd_decode.sv
design/mainbd_cabinet.sv
design/mainbd_ctrl.sv
design/mainbd_ram.sv
design/mainbd_rdmux.sv
design/mainbd_top.sv
verification/mainbd_tb.sv

// ==== design/mainbd_cabinet.sv ====
module mainbd_cabinet (
    input  logic                 clk,
    input  mainbd_pkg::cpu_bus_t bus,
    input  mainbd_pkg::cabinet_t cab,
    input  mainbd_pkg::dip_t     dip,
    output logic [7:0]           cabinet_q
);

    // Joystick byte as wired on the board
    // Buttons on 5:4, directions with the pairs swapped
    function automatic logic [7:0] fmt_joy(input logic [5:0] joy);
        fmt_joy = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    // Registered every cycle from the low address bits
    always_ff @(posedge clk) begin
        case (bus.addr[1:0])
            2'd0: cabinet_q <= {3'b111, cab.start_button, cab.service, cab.coin_input};
            2'd1: cabinet_q <= fmt_joy(cab.joystick1);
            2'd2: cabinet_q <= fmt_joy(cab.joystick2);
            default: cabinet_q <= {6'h3f, dip.dipsw_c};   // Third DIP bank, unused bits high
        endcase
    end

endmodule

// ==== design/mainbd_ctrl.sv ====
module mainbd_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_cen,
    input  mainbd_pkg::cpu_bus_t    bus,
    input  mainbd_pkg::chip_sel_t   sel,
    input  logic                    lvbl,
    input  logic                    dip_pause,
    output mainbd_pkg::board_ctrl_t ctrl,
    output logic                    irq_n
);
    import mainbd_pkg::*;

    logic cpu_wr;        // Write strobe for this cycle
    logic irq_clrn;      // Latch bit 7, low holds the IRQ FF clear
    logic irq_trig;
    logic irq_trig_l;    // Trigger one clock ago
    logic irq_q;

    assign cpu_wr   = cpu_cen && !bus.rnw;
    assign irq_trig = ~lvbl & dip_pause;
    assign irq_n    = ~irq_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= '0;
            irq_clrn <= 1'b0;
        end else if (cpu_wr) begin
            if (sel.iow) begin
                // 74LS259, data bit 0 into the addressed output
                case (bus.addr[2:0])
                    LATCH_SND_ON:   ctrl.snd_on <= bus.dout[0];
                    LATCH_FLIP:     ctrl.flip   <= bus.dout[0];
                    LATCH_IRQ_CLRN: irq_clrn    <= bus.dout[0];
                    default: begin
                    end
                endcase
            end
            if (sel.color) ctrl.pal_sel   <= bus.dout[2:0];
            if (sel.snd)   ctrl.snd_latch <= bus.dout;
        end
    end

    // Vblank IRQ flip-flop, clear wins over set
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            irq_trig_l <= irq_trig;
            if (!irq_clrn) begin
                irq_q <= 1'b0;
            end else if (irq_trig && !irq_trig_l) begin
                irq_q <= 1'b1;      // Start of vblank
            end
        end
    end

    // IRQ released the cycle after the CPU drops irq_clrn
    assert property (@(posedge clk) disable iff (rst) !irq_clrn |=> irq_n)
        else $error("irq_n low while irq_clrn is 0");

    // Palette only moves with a CPU cycle
    assert property (@(posedge clk) disable iff (rst) !cpu_cen |=> $stable(ctrl.pal_sel))
        else $error("pal_sel changed without cpu_cen");

endmodule

// ==== design/mainbd_decode.sv ====
module mainbd_decode (
    input  mainbd_pkg::cpu_bus_t  bus,
    output mainbd_pkg::chip_sel_t sel
);

    logic io_win;   // 2000-3FFF with a valid cycle

    assign io_win = bus.vma && (bus.addr[15:13] == 3'd1);

    always_comb begin
        sel     = '0;
        // Program ROM 6000-FFFF, read only
        sel.rom = bus.vma && bus.rnw && (bus.addr[15:13] > 3'd2);
        if (io_win) begin
            case (bus.addr[12:11])
                2'd0: begin
                    // I/O page 2000-27FF, decoded per 256 bytes
                    case (bus.addr[10:8])
                        3'd0: sel.iow     = 1'b1;   // 2000
                        3'd2: sel.color   = 1'b1;   // 2200
                        3'd3: sel.intshow = 1'b1;   // 2300
                        3'd4: begin
                            sel.ior = 1'b1;         // 2400-24FF
                            sel.snd = ~bus.rnw;     // Sound latch shares the page
                        end
                        3'd5: begin
                            // 2500 even is DIP A, odd is DIP B
                            sel.in5 = ~bus.addr[0];
                            sel.in6 = bus.addr[0];
                        end
                        default: begin
                            // 2100 watchdog and the rest float
                        end
                    endcase
                end
                2'd1: sel.objram = 1'b1;   // 2800-2FFF
                2'd2: sel.ram    = 1'b1;   // 3000-37FF, mirrored work RAM
                2'd3: sel.vram   = 1'b1;   // 3800-3FFF
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== design/mainbd_pkg.sv ====
package mainbd_pkg;

    // CPU bus as seen from the board, sampled on clk
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;     // High on reads
        logic        vma;     // Valid memory address
        logic [7:0]  dout;    // CPU write data
    } cpu_bus_t;

    // One-hot-ish chip selects, snd qualifies ior on writes
    typedef struct packed {
        logic rom;
        logic iow;            // 74LS259 output latch
        logic color;          // Palette bank
        logic intshow;        // Scroll chip read back
        logic ior;            // Cabinet inputs and sound latch
        logic snd;
        logic in5;            // DIP A
        logic in6;            // DIP B
        logic objram;
        logic ram;
        logic vram;
    } chip_sel_t;

    typedef struct packed {
        logic [1:0] start_button;
        logic [1:0] coin_input;
        logic [5:0] joystick1;
        logic [5:0] joystick2;
        logic       service;
    } cabinet_t;

    typedef struct packed {
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic [1:0] dipsw_c;
        logic       dip_pause;   // Low freezes the game by holding off vblank IRQ
    } dip_t;

    typedef struct packed {
        logic [7:0] snd_latch;
        logic       snd_on;
        logic       flip;
        logic [2:0] pal_sel;
    } board_ctrl_t;

    // Output latch bit positions, A2..A0 of the write
    localparam logic [2:0] LATCH_SND_ON   = 3'd2;
    localparam logic [2:0] LATCH_FLIP     = 3'd6;
    localparam logic [2:0] LATCH_IRQ_CLRN = 3'd7;

    localparam logic [7:0] OPEN_BUS = 8'hff;   // Pulled-up data bus

endpackage

// ==== design/mainbd_ram.sv ====
module mainbd_ram #(
    parameter int RAM_AW = 10
) (
    input  logic                 clk,
    input  logic                 cpu_cen,
    input  logic                 we,
    input  mainbd_pkg::cpu_bus_t bus,
    output logic [7:0]           ram_dout
);

    logic [7:0]        mem [0:(1 << RAM_AW) - 1];
    logic [RAM_AW-1:0] addr;    // Upper bits ignored, RAM mirrors in its window
    logic              wr;

    assign addr = bus.addr[RAM_AW-1:0];
    assign wr   = cpu_cen && we && !bus.rnw;

    always_ff @(posedge clk) begin
        if (wr) mem[addr] <= bus.dout;
        ram_dout <= mem[addr];   // Old data on a same-cycle write
    end

    // The select comes from the decoder, which must qualify it with vma
    assert property (@(posedge clk) wr |-> bus.vma)
        else $error("RAM written without vma");

endmodule

// ==== design/mainbd_rdmux.sv ====
module mainbd_rdmux (
    input  logic                  clk,
    input  logic                  rst,
    input  mainbd_pkg::chip_sel_t sel,
    input  logic [7:0]            rom_data,
    input  logic [7:0]            vram_dout,
    input  logic [7:0]            ram_dout,
    input  logic [7:0]            vscr_dout,
    input  logic [7:0]            obj_dout,
    input  logic [7:0]            cabinet_q,
    input  mainbd_pkg::dip_t      dip,
    output logic [7:0]            cpu_din
);
    import mainbd_pkg::*;

    // Priority order as on the board, ROM first
    always_ff @(posedge clk) begin
        if (rst)              cpu_din <= OPEN_BUS;
        else if (sel.rom)     cpu_din <= rom_data;
        else if (sel.vram)    cpu_din <= vram_dout;
        else if (sel.ram)     cpu_din <= ram_dout;
        else if (sel.intshow) cpu_din <= vscr_dout;   // Scroll chip
        else if (sel.objram)  cpu_din <= obj_dout;
        else if (sel.ior)     cpu_din <= cabinet_q;
        else if (sel.in6)     cpu_din <= dip.dipsw_b;
        else if (sel.in5)     cpu_din <= dip.dipsw_a;
        else                  cpu_din <= OPEN_BUS;
    end

    // snd is left out, it only qualifies ior on writes
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({sel.rom, sel.iow, sel.color, sel.intshow, sel.ior,
                  sel.in5, sel.in6, sel.objram, sel.ram, sel.vram}))
        else $error("More than one chip select active");

endmodule

// ==== design/mainbd_top.sv ====
module mainbd_top #(
    parameter int RAM_AW = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_cen,
    input  mainbd_pkg::cpu_bus_t    bus,
    input  mainbd_pkg::cabinet_t    cab,
    input  mainbd_pkg::dip_t        dip,
    input  logic                    lvbl,        // Low during vblank
    input  logic [7:0]              rom_data,
    input  logic [7:0]              vram_dout,
    input  logic [7:0]              vscr_dout,
    input  logic [7:0]              obj_dout,
    output logic [7:0]              cpu_din,
    output logic [15:0]             rom_addr,
    output logic                    rom_cs,
    output logic                    vram_cs,
    output logic                    objram_cs,
    output logic                    cpu_rnw,
    output logic [7:0]              cpu_dout,
    output mainbd_pkg::board_ctrl_t ctrl,
    output logic                    irq_n
);
    import mainbd_pkg::*;

    chip_sel_t  sel;
    logic [7:0] cabinet_q;
    logic [7:0] ram_dout;

    // Bus straight out to ROM and video
    assign rom_addr  = bus.addr;
    assign cpu_rnw   = bus.rnw;
    assign cpu_dout  = bus.dout;
    assign rom_cs    = sel.rom;
    assign vram_cs   = sel.vram;
    assign objram_cs = sel.objram;

    mainbd_decode u_decode (
        .bus (bus),
        .sel (sel)
    );

    mainbd_cabinet u_cabinet (
        .clk       (clk),
        .bus       (bus),
        .cab       (cab),
        .dip       (dip),
        .cabinet_q (cabinet_q)
    );

    mainbd_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus       (bus),
        .sel       (sel),
        .lvbl      (lvbl),
        .dip_pause (dip.dip_pause),
        .ctrl      (ctrl),
        .irq_n     (irq_n)
    );

    mainbd_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk      (clk),
        .cpu_cen  (cpu_cen),
        .we       (sel.ram),   // Direction checked inside
        .bus      (bus),
        .ram_dout (ram_dout)
    );

    mainbd_rdmux u_rdmux (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .rom_data  (rom_data),
        .vram_dout (vram_dout),
        .ram_dout  (ram_dout),
        .vscr_dout (vscr_dout),
        .obj_dout  (obj_dout),
        .cabinet_q (cabinet_q),
        .dip       (dip),
        .cpu_din   (cpu_din)
    );

endmodule

// ==== verification/mainbd_tb.sv ====
module mainbd_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mainbd_pkg::*;

    localparam int         RAM_AW      = 10;
    localparam logic [1:0] OP_RD       = 2'd0;   // Read, byte given in the table
    localparam logic [1:0] OP_RDM      = 2'd1;   // Read, byte from the reference model
    localparam logic [1:0] OP_WR       = 2'd2;
    localparam logic [1:0] OP_WRN      = 2'd3;   // Write cycle with cpu_cen low
    localparam logic [7:0] VRAM_BYTE   = 8'hc3;
    localparam logic [7:0] VSCR_BYTE   = 8'h3c;
    localparam logic [7:0] OBJ_BYTE    = 8'h96;
    localparam logic [7:0] DIP_A       = 8'hb6;
    localparam logic [7:0] DIP_B       = 8'h4d;
    localparam int         IRQ_TIMEOUT = 10;     // Clocks

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  want;
        logic [2:0]  cs;     // rom_cs, vram_cs, objram_cs
    } step_t;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    logic        lvbl;
    cpu_bus_t    bus;
    cabinet_t    cab;
    dip_t        dip;
    logic [7:0]  rom_data;
    logic [7:0]  vram_dout;
    logic [7:0]  vscr_dout;
    logic [7:0]  obj_dout;
    logic [7:0]  cpu_din;
    logic [15:0] rom_addr;
    logic        rom_cs;
    logic        vram_cs;
    logic        objram_cs;
    logic        cpu_rnw;
    logic [7:0]  cpu_dout;
    board_ctrl_t ctrl;
    logic        irq_n;

    step_t       steps [0:79];
    int          n_steps;
    int          err_count;
    logic [31:0] rng;
    logic [7:0]  model_ram [0:(1 << RAM_AW) - 1];
    board_ctrl_t model_ctrl;

    mainbd_top #(.RAM_AW(RAM_AW)) dut0 (.*);

    assign rom_data = rom_byte(rom_addr);   // ROM image follows the address

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rom_byte(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    // Two high bits, buttons, then directions 2 3 0 1
    function automatic logic [7:0] joy_byte(input logic [5:0] j);
        logic [7:0] r;
        r      = 8'hc0;
        r[5:4] = j[5:4];
        r[3]   = j[2];
        r[2]   = j[3];
        r[1]   = j[0];
        r[0]   = j[1];
        return r;
    endfunction

    function automatic logic [7:0] cabinet_byte(input logic [1:0] idx);
        logic [7:0] r;
        r = 8'hff;
        case (idx)
            2'd0: begin
                r[4:3] = cab.start_button;
                r[2]   = cab.service;
                r[1:0] = cab.coin_input;
            end
            2'd1: r = joy_byte(cab.joystick1);
            2'd2: r = joy_byte(cab.joystick2);
            default: r[1:0] = dip.dipsw_c;
        endcase
        return r;
    endfunction

    // Read value from the memory map, floating bus where nothing answers
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        logic [7:0] r;
        r = OPEN_BUS;
        if (a >= 16'h6000) r = rom_byte(a);
        else if (a < 16'h2000 || a >= 16'h4000) r = OPEN_BUS;
        else if (a >= 16'h3800) r = VRAM_BYTE;
        else if (a >= 16'h3000) r = model_ram[a[RAM_AW-1:0]];
        else if (a >= 16'h2800) r = OBJ_BYTE;
        else if (a[15:8] == 8'h23) r = VSCR_BYTE;
        else if (a[15:8] == 8'h24) r = cabinet_byte(a[1:0]);
        else if (a[15:8] == 8'h25) r = a[0] ? DIP_B : DIP_A;
        return r;
    endfunction

    task automatic update_model(input logic [15:0] a, input logic [7:0] d);
        if (a[15:8] == 8'h20 && a[2:0] == LATCH_SND_ON) model_ctrl.snd_on = d[0];
        if (a[15:8] == 8'h20 && a[2:0] == LATCH_FLIP) model_ctrl.flip = d[0];
        if (a[15:8] == 8'h22) model_ctrl.pal_sel = d[2:0];
        if (a[15:8] == 8'h24) model_ctrl.snd_latch = d;
        if (a[15:11] == 5'b00110) model_ram[a[RAM_AW-1:0]] = d;   // 3000-37FF
    endtask

    task automatic abort_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic add_step(input logic [1:0] op, input logic [15:0] a, input logic [7:0] d,
                            input logic [7:0] want, input logic [2:0] cs);
        steps[n_steps] = '{op: op, addr: a, data: d, want: want, cs: cs};
        n_steps++;
    endtask

    task automatic build_steps();
        logic [15:0] ram_addr [0:15];
        logic [7:0]  first_data;
        int          i;
        add_step(OP_RD, 16'h2600, 8'h00, OPEN_BUS, 3'b000);   // Unmapped I/O page
        add_step(OP_RD, 16'h2100, 8'h00, OPEN_BUS, 3'b000);
        add_step(OP_RD, 16'h1000, 8'h00, OPEN_BUS, 3'b000);   // Below the window
        add_step(OP_RD, 16'h4000, 8'h00, OPEN_BUS, 3'b000);
        add_step(OP_RD, 16'h5fff, 8'h00, OPEN_BUS, 3'b000);
        add_step(OP_RD, 16'h6000, 8'h00, rom_byte(16'h6000), 3'b100);
        add_step(OP_RD, 16'hffff, 8'h00, rom_byte(16'hffff), 3'b100);
        add_step(OP_WR, 16'h8000, 8'h55, 8'h00, 3'b000);      // ROM not selected on writes
        add_step(OP_RD, 16'h3800, 8'h00, VRAM_BYTE, 3'b010);
        add_step(OP_RD, 16'h3fff, 8'h00, VRAM_BYTE, 3'b010);
        add_step(OP_RD, 16'h2800, 8'h00, OBJ_BYTE, 3'b001);
        add_step(OP_RD, 16'h2fff, 8'h00, OBJ_BYTE, 3'b001);
        add_step(OP_RD, 16'h2300, 8'h00, VSCR_BYTE, 3'b000);
        for (i = 0; i < 4; i++) begin
            add_step(OP_RDM, 16'h2400 + 16'(i), 8'h00, 8'h00, 3'b000);
        end
        add_step(OP_RDM, 16'h24fe, 8'h00, 8'h00, 3'b000);     // Cabinet mirrors in its page
        add_step(OP_RD, 16'h2500, 8'h00, DIP_A, 3'b000);
        add_step(OP_RD, 16'h2501, 8'h00, DIP_B, 3'b000);
        add_step(OP_WR, 16'h2002, 8'h01, 8'h00, 3'b000);      // snd_on
        add_step(OP_WR, 16'h2006, 8'h01, 8'h00, 3'b000);      // flip
        add_step(OP_WR, 16'h2003, 8'h01, 8'h00, 3'b000);      // Unused latch bit
        add_step(OP_WR, 16'h2200, 8'hfd, 8'h00, 3'b000);
        add_step(OP_WR, 16'h2400, 8'ha7, 8'h00, 3'b000);      // Sound latch
        add_step(OP_WRN, 16'h2200, 8'h07, 8'h00, 3'b000);
        add_step(OP_WR, 16'h2002, 8'h00, 8'h00, 3'b000);
        add_step(OP_WR, 16'h2200, 8'h02, 8'h00, 3'b000);
        // Work RAM at 3000-33FF, random bytes
        for (i = 0; i < 16; i++) begin
            rng = xorshift32(rng);
            ram_addr[i] = {6'b001100, rng[9:0]};
            if (i == 0) first_data = rng[27:20];
            add_step(OP_WR, ram_addr[i], rng[27:20], 8'h00, 3'b000);
        end
        for (i = 0; i < 16; i++) begin
            add_step(OP_RDM, ram_addr[i], 8'h00, 8'h00, 3'b000);
        end
        add_step(OP_WRN, ram_addr[0], ~first_data, 8'h00, 3'b000);
        add_step(OP_RDM, ram_addr[0], 8'h00, 8'h00, 3'b000);
    endtask

    // One CPU cycle, bus changes on the rising edge, sampling on the falling one
    task automatic apply_step(input step_t s);
        logic [7:0] want;
        logic       is_rd;
        is_rd = (s.op == OP_RD || s.op == OP_RDM);
        @(posedge clk);
        bus.addr <= s.addr;
        bus.rnw  <= is_rd;
        bus.vma  <= 1'b1;
        bus.dout <= s.data;
        cpu_cen  <= (s.op == OP_WR);
        @(negedge clk);
        assert ({rom_cs, vram_cs, objram_cs} === s.cs)
            else abort_run($sformatf("FAILED at %0t: selects %b at %h, expected %b",
                                     $time, {rom_cs, vram_cs, objram_cs}, s.addr, s.cs));
        // Address, direction and write data pass straight through to the board
        assert (rom_addr === s.addr && cpu_rnw === is_rd && cpu_dout === s.data)
            else abort_run($sformatf("FAILED at %0t: bus out %h %b %h, expected %h %b %h",
                                     $time, rom_addr, cpu_rnw, cpu_dout,
                                     s.addr, is_rd, s.data));
        if (s.op == OP_WR || s.op == OP_WRN) begin
            @(posedge clk);          // Write edge
            cpu_cen <= 1'b0;
            bus.rnw <= 1'b1;
            if (s.op == OP_WR) update_model(s.addr, s.data);
            @(negedge clk);
            assert (ctrl === model_ctrl)
                else abort_run($sformatf("FAILED at %0t: ctrl %h after write %h, expected %h",
                                         $time, ctrl, s.addr, model_ctrl));
        end else begin
            want = (s.op == OP_RDM) ? expected_read(s.addr) : s.want;
            repeat (2) @(posedge clk);   // Source register, then read mux register
            @(negedge clk);
            assert (cpu_din === want)
                else abort_run($sformatf("FAILED at %0t: read %h gave %h, expected %h",
                                         $time, s.addr, cpu_din, want));
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq_n !== level && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (irq_n === level)
            else abort_run($sformatf("Timed out at %0t waiting for irq_n to become %b",
                                     $time, level));
    endtask

    task automatic run_irq_test();
        apply_step('{op: OP_WR, addr: 16'h2007, data: 8'h01, want: 8'h00, cs: 3'b000});
        @(posedge clk);
        lvbl <= 1'b0;            // Start of vblank
        wait_irq(1'b0);
        @(posedge clk);
        lvbl <= 1'b1;
        apply_step('{op: OP_WR, addr: 16'h2007, data: 8'h00, want: 8'h00, cs: 3'b000});
        wait_irq(1'b1);
        @(posedge clk);
        lvbl <= 1'b0;            // Ignored while irq_clrn is 0
        repeat (8) begin
            @(negedge clk);
            assert (irq_n === 1'b1)
                else abort_run($sformatf("FAILED at %0t: irq_n low with irq_clrn 0", $time));
        end
        @(posedge clk);
        lvbl <= 1'b1;
    endtask

    initial begin : main_seq
        int i;
        err_count = 0;
        n_steps   = 0;
        rng       = 32'd58;
        rst       = 1'b1;
        cpu_cen   = 1'b0;
        lvbl      = 1'b1;
        bus       = '0;
        bus.rnw   = 1'b1;
        rng       = xorshift32(rng);
        cab       = rng[16:0];   // Buttons, coins and joysticks at random
        dip.dipsw_a   = DIP_A;
        dip.dipsw_b   = DIP_B;
        dip.dipsw_c   = 2'b10;
        dip.dip_pause = 1'b1;
        vram_dout  = VRAM_BYTE;
        vscr_dout  = VSCR_BYTE;
        obj_dout   = OBJ_BYTE;
        model_ctrl = '0;
        build_steps();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (ctrl === '0 && irq_n === 1'b1 && cpu_din === OPEN_BUS)
            else abort_run($sformatf("FAILED at %0t: after reset ctrl %h irq_n %b cpu_din %h",
                                     $time, ctrl, irq_n, cpu_din));
        for (i = 0; i < n_steps; i++) begin
            apply_step(steps[i]);
        end
        run_irq_test();
        if (err_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Errors were found");
        end
    end

endmodule
